/* hdl/alu_pkg.sv */
// ALU package
// Operation codes, unit select encoding
// Operand/result word and flag typedefs
// Command and unit result structs

package alu_pkg;

    // Signed operand and result word
    typedef logic signed [31:0] alu_word_t;

    // Bit 1 error, bit 0 zero
    typedef logic [1:0] alu_flags_t;

    ////////////////////////////////////////
    // Operation encoding
    // 00xx arithmetic, 01xx bitwise, 1x__ special
    ////////////////////////////////////////
    typedef enum logic [3:0] {
        OP_ADD        = 4'b0000,
        OP_SUB        = 4'b0001,
        OP_MUL        = 4'b0010,
        OP_DIV        = 4'b0011,
        OP_NOT        = 4'b0100,
        OP_AND        = 4'b0101,
        OP_OR         = 4'b0110,
        OP_XOR        = 4'b0111,
        OP_WRITE_HIGH = 4'b1000,
        OP_WRITE_LOW  = 4'b1001,
        OP_ITOF       = 4'b1010,
        OP_FTOI       = 4'b1011
    } alu_op_e;

    // Unit picked by decode
    typedef enum logic [1:0] {
        UNIT_ARITH   = 2'b00,
        UNIT_CONVERT = 2'b01,
        UNIT_LOGIC   = 2'b10
    } alu_unit_e;

    typedef struct packed {
        alu_op_e   op;
        alu_word_t op1;
        alu_word_t op2;
    } alu_cmd_t;

    typedef struct packed {
        alu_word_t  value;
        alu_flags_t flags;
        logic       valid;
    } unit_result_t;

endpackage

/* hdl/apb_pkg.sv */
// APB package
// Address and data typedefs
// Request and response structs
// Register map of the ALU slave

package apb_pkg;

    typedef logic [31:0] apb_addr_t;
    typedef logic [31:0] apb_data_t;

    // Master to slave
    typedef struct packed {
        apb_addr_t paddr;
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_data_t pwdata;
    } apb_req_t;

    // Slave to master
    typedef struct packed {
        apb_data_t prdata;
        logic      pready;
        logic      pslverr;
    } apb_rsp_t;

    // Register offsets
    localparam apb_addr_t REG_OP1    = 32'h00;
    localparam apb_addr_t REG_OP2    = 32'h04;
    localparam apb_addr_t REG_CTRL   = 32'h08;
    localparam apb_addr_t REG_RESULT = 32'h0C;
    // STATUS: bit 0 busy, bit 1 done, bits 3:2 flags
    localparam apb_addr_t REG_STATUS = 32'h10;

endpackage

/* hdl/alu_apb_regs.sv */
// APB register file of the ALU
// OP1, OP2, CTRL, RESULT and STATUS registers
// Command launch, busy and sticky done status

`timescale 1ns/1ps

module alu_apb_regs import alu_pkg::*, apb_pkg::*; #(
    parameter int ADDR_WIDTH = 8
) (
    input  logic       clk,
    input  logic       reset,
    input  apb_req_t   apb_req,
    output apb_rsp_t   apb_rsp,
    output alu_cmd_t   cmd,
    output logic       cmd_start,
    input  alu_word_t  result_value,
    input  alu_flags_t result_flags,
    input  logic       result_done
);

    logic [ADDR_WIDTH-1:0] offset;
    logic                  in_window;
    logic                  wr_access;
    logic                  rd_access;
    logic                  sel_op1, sel_op2, sel_ctrl, sel_result, sel_status;
    logic                  wr_err, rd_err;
    logic                  ctrl_accept;
    alu_word_t             op1_q, op2_q;
    alu_op_e               op_q;
    logic                  busy, done;

    // Bits above the window must be zero
    assign offset    = apb_req.paddr[ADDR_WIDTH-1:0];
    assign in_window = (apb_req.paddr >> ADDR_WIDTH) == '0;

    assign wr_access = apb_req.psel && apb_req.penable && apb_req.pwrite;
    assign rd_access = apb_req.psel && apb_req.penable && !apb_req.pwrite;

    assign sel_op1    = in_window && offset == REG_OP1[ADDR_WIDTH-1:0];
    assign sel_op2    = in_window && offset == REG_OP2[ADDR_WIDTH-1:0];
    assign sel_ctrl   = in_window && offset == REG_CTRL[ADDR_WIDTH-1:0];
    assign sel_result = in_window && offset == REG_RESULT[ADDR_WIDTH-1:0];
    assign sel_status = in_window && offset == REG_STATUS[ADDR_WIDTH-1:0];

    // Read-only or unmapped writes fail, so does CTRL while busy
    assign wr_err = !(sel_op1 || sel_op2 || sel_ctrl) || (sel_ctrl && busy);
    assign rd_err = !(sel_op1 || sel_op2 || sel_ctrl || sel_result || sel_status);
    assign ctrl_accept = wr_access && sel_ctrl && !busy;

    ////////////////////////////////////////
    // APB response
    ////////////////////////////////////////
    always_comb begin
        apb_rsp.pready  = 1'b1;
        apb_rsp.pslverr = (wr_access && wr_err) || (rd_access && rd_err);
        apb_rsp.prdata  = '0;
        if (rd_access) begin
            if (sel_op1)
                apb_rsp.prdata = op1_q;
            else if (sel_op2)
                apb_rsp.prdata = op2_q;
            else if (sel_ctrl)
                apb_rsp.prdata = {28'd0, op_q};
            else if (sel_result)
                apb_rsp.prdata = result_value;
            else if (sel_status)
                apb_rsp.prdata = {28'd0, result_flags, done, busy};
        end
    end

    ////////////////////////////////////////
    // Registers and status
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            op1_q     <= '0;
            op2_q     <= '0;
            op_q      <= OP_ADD;
            busy      <= 1'b0;
            done      <= 1'b0;
            cmd_start <= 1'b0;
        end else begin
            cmd_start <= ctrl_accept;
            if (wr_access && sel_op1)
                op1_q <= apb_req.pwdata;
            if (wr_access && sel_op2)
                op2_q <= apb_req.pwdata;
            if (ctrl_accept) begin
                op_q <= alu_op_e'(apb_req.pwdata[3:0]);
                busy <= 1'b1;
                done <= 1'b0;
            end else if (result_done) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    assign cmd = '{op: op_q, op1: op1_q, op2: op2_q};

endmodule

/* hdl/alu_op_decode.sv */
// Operation decoder
// Registers the command, folds 11xx onto 10xx
// and raises the start of one unit

`timescale 1ns/1ps

module alu_op_decode import alu_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  alu_cmd_t cmd,
    input  logic     cmd_start,
    output alu_cmd_t dec_cmd,
    output logic     arith_start,
    output logic     convert_start,
    output logic     logic_start
);

    alu_unit_e unit;
    alu_op_e   norm_op;

    // Group from the upper bits, special group split by the low pair
    always_comb begin
        case (cmd.op[3:2])
            2'b00:   unit = UNIT_ARITH;
            2'b01:   unit = UNIT_LOGIC;
            default: unit = cmd.op[1] ? UNIT_CONVERT : UNIT_LOGIC;
        endcase
    end

    assign norm_op = alu_op_e'({cmd.op[3], cmd.op[2] & ~cmd.op[3], cmd.op[1:0]});

    always_ff @(posedge clk) begin
        if (cmd_start)
            dec_cmd <= '{op: norm_op, op1: cmd.op1, op2: cmd.op2};
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            arith_start   <= 1'b0;
            convert_start <= 1'b0;
            logic_start   <= 1'b0;
        end else begin
            arith_start   <= cmd_start && unit == UNIT_ARITH;
            convert_start <= cmd_start && unit == UNIT_CONVERT;
            logic_start   <= cmd_start && unit == UNIT_LOGIC;
        end
    end

endmodule

/* hdl/alu_int_arith.sv */
// Integer arithmetic unit
// One-cycle add/sub with signed overflow
// Shift-add multiply and restoring divide on magnitudes

`timescale 1ns/1ps

module alu_int_arith import alu_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  alu_cmd_t     cmd,
    input  logic         start,
    output unit_result_t res
);

    typedef enum logic [2:0] {IDLE, ADDSUB, MULT, DIVIDE, FINISH} arith_state_e;

    arith_state_e state;
    alu_op_e      op_q;
    alu_word_t    a_q;
    logic [31:0]  b_q;
    logic [32:0]  acc;
    logic [4:0]   step;
    logic         neg, err;
    logic [31:0]  mag_a, mag_b, mag;
    logic [32:0]  rem_shift, rem_diff;
    alu_word_t    sum, final_value;
    logic         b_sign, ovf;

    assign mag_a = cmd.op1[31] ? -cmd.op1 : cmd.op1;
    assign mag_b = cmd.op2[31] ? -cmd.op2 : cmd.op2;

    // Add/sub path, b sign flipped for subtract
    assign sum    = (op_q == OP_SUB) ? a_q - alu_word_t'(b_q) : a_q + alu_word_t'(b_q);
    assign b_sign = b_q[31] ^ (op_q == OP_SUB);
    assign ovf    = (a_q[31] == b_sign) && (sum[31] != a_q[31]);

    // One restoring step, b_q shifts dividend out and quotient in
    assign rem_shift = {acc[31:0], b_q[31]};
    assign rem_diff  = rem_shift - {1'b0, a_q};

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        op_q <= cmd.op;
                        step <= '0;
                        acc  <= '0;
                        err  <= 1'b0;
                        neg  <= cmd.op1[31] ^ cmd.op2[31];
                        if (cmd.op == OP_MUL) begin
                            a_q   <= mag_a;
                            b_q   <= mag_b;
                            state <= MULT;
                        end else if (cmd.op == OP_DIV && cmd.op2 == '0) begin
                            // Divide by zero gives all ones
                            b_q   <= '1;
                            neg   <= 1'b0;
                            err   <= 1'b1;
                            state <= FINISH;
                        end else if (cmd.op == OP_DIV) begin
                            a_q   <= mag_b;
                            b_q   <= mag_a;
                            state <= DIVIDE;
                        end else begin
                            a_q   <= cmd.op1;
                            b_q   <= cmd.op2;
                            state <= ADDSUB;
                        end
                    end
                end
                ADDSUB: begin
                    acc   <= {1'b0, sum};
                    err   <= ovf;
                    neg   <= 1'b0;
                    state <= FINISH;
                end
                MULT: begin
                    if (b_q[0])
                        acc[31:0] <= acc[31:0] + a_q;
                    a_q  <= a_q << 1;
                    b_q  <= b_q >> 1;
                    step <= step + 5'd1;
                    if (step == 5'd31)
                        state <= FINISH;
                end
                DIVIDE: begin
                    acc  <= rem_diff[32] ? rem_shift : rem_diff;
                    b_q  <= {b_q[30:0], ~rem_diff[32]};
                    step <= step + 5'd1;
                    if (step == 5'd31)
                        state <= FINISH;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Quotient in b_q, product and sum in acc
    assign mag         = (op_q == OP_DIV) ? b_q : acc[31:0];
    assign final_value = neg ? -mag : mag;

    assign res.value = final_value;
    assign res.flags = {err, final_value == '0};
    assign res.valid = state == FINISH;

endmodule

/* hdl/alu_fp_convert.sv */
// Float conversion unit
// Int-to-float by one-bit normalizing shifts
// Float-to-int by one-bit mantissa shifts with saturation

`timescale 1ns/1ps

module alu_fp_convert import alu_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  alu_cmd_t     cmd,
    input  logic         start,
    output unit_result_t res
);

    typedef enum logic [1:0] {IDLE, ITOF_NORM, FTOI_SHIFT, FINISH} conv_state_e;

    conv_state_e state;
    logic [31:0] mag;
    logic [7:0]  exp_q;
    logic [4:0]  shift_cnt;
    logic        shift_left;
    logic        sign;
    alu_word_t   result_q;
    logic [7:0]  f_exp;
    logic [31:0] int_mag;

    assign f_exp   = cmd.op1[30:23];
    assign int_mag = cmd.op1[31] ? -cmd.op1 : cmd.op1;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        sign <= cmd.op1[31];
                        if (cmd.op == OP_ITOF) begin
                            mag   <= int_mag;
                            // 127 + 31, lowered once per shift
                            exp_q <= 8'd158;
                            if (cmd.op1 == '0) begin
                                result_q <= '0;
                                state    <= FINISH;
                            end else begin
                                state <= ITOF_NORM;
                            end
                        end else if (f_exp < 8'd127) begin
                            // Fractions, zero and denormals
                            result_q <= '0;
                            state    <= FINISH;
                        end else if (f_exp >= 8'd158) begin
                            // Out of range, infinity and NaN
                            result_q <= cmd.op1[31] ? 32'h8000_0000 : 32'h7FFF_FFFF;
                            state    <= FINISH;
                        end else begin
                            mag        <= {8'd0, 1'b1, cmd.op1[22:0]};
                            shift_left <= f_exp >= 8'd150;
                            shift_cnt  <= (f_exp >= 8'd150) ? 5'(f_exp - 8'd150)
                                                            : 5'(8'd150 - f_exp);
                            state      <= FTOI_SHIFT;
                        end
                    end
                end
                ITOF_NORM: begin
                    if (mag[31]) begin
                        result_q <= {sign, exp_q, mag[30:8]};
                        state    <= FINISH;
                    end else begin
                        mag   <= mag << 1;
                        exp_q <= exp_q - 8'd1;
                    end
                end
                FTOI_SHIFT: begin
                    if (shift_cnt == '0) begin
                        result_q <= sign ? -mag : mag;
                        state    <= FINISH;
                    end else begin
                        mag       <= shift_left ? mag << 1 : mag >> 1;
                        shift_cnt <= shift_cnt - 5'd1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign res.value = result_q;
    assign res.flags = {1'b0, result_q == '0};
    assign res.valid = state == FINISH;

endmodule

/* hdl/alu_result.sv */
// Result stage
// Bitwise and half-word write ops
// Result select, value/flag register and done pulse

`timescale 1ns/1ps

module alu_result import alu_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  alu_cmd_t     cmd,
    input  logic         logic_start,
    input  unit_result_t arith_res,
    input  unit_result_t convert_res,
    output alu_word_t    value,
    output alu_flags_t   flags,
    output logic         done
);

    alu_word_t    logic_value, logic_value_q;
    logic         logic_valid;
    unit_result_t sel_res;

    always_comb begin
        case (cmd.op)
            OP_NOT:        logic_value = ~cmd.op1;
            OP_AND:        logic_value = cmd.op1 & cmd.op2;
            OP_OR:         logic_value = cmd.op1 | cmd.op2;
            OP_XOR:        logic_value = cmd.op1 ^ cmd.op2;
            OP_WRITE_HIGH: logic_value = {cmd.op2[15:0], cmd.op1[15:0]};
            OP_WRITE_LOW:  logic_value = {cmd.op1[31:16], cmd.op2[15:0]};
            default:       logic_value = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        logic_value_q <= logic_value;
        if (reset)
            logic_valid <= 1'b0;
        else
            logic_valid <= logic_start;
    end

    // Only one unit answers per command
    always_comb begin
        if (arith_res.valid)
            sel_res = arith_res;
        else if (convert_res.valid)
            sel_res = convert_res;
        else
            sel_res = '{value: logic_value_q, flags: '0, valid: logic_valid};
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            value <= '0;
            flags <= '0;
            done  <= 1'b0;
        end else begin
            done <= sel_res.valid;
            if (sel_res.valid) begin
                value <= sel_res.value;
                flags <= sel_res.flags;
            end
        end
    end

endmodule

/* hdl/alu_top.sv */
// ALU top level
// APB register file, decoder, arithmetic and
// conversion units and the result stage

`timescale 1ns/1ps

module alu_top import alu_pkg::*, apb_pkg::*; #(
    parameter int ADDR_WIDTH = 8
) (
    input  logic     clk,
    input  logic     reset,
    input  apb_req_t apb_req,
    output apb_rsp_t apb_rsp
);

    alu_cmd_t     cmd, dec_cmd;
    logic         cmd_start;
    logic         arith_start, convert_start, logic_start;
    unit_result_t arith_res, convert_res;
    alu_word_t    result_value;
    alu_flags_t   result_flags;
    logic         result_done;

    alu_apb_regs #(
        .ADDR_WIDTH(ADDR_WIDTH)
    ) u_regs (
        .clk(clk), .reset(reset),
        .apb_req(apb_req), .apb_rsp(apb_rsp),
        .cmd(cmd), .cmd_start(cmd_start),
        .result_value(result_value), .result_flags(result_flags),
        .result_done(result_done)
    );

    alu_op_decode u_decode (
        .clk(clk), .reset(reset),
        .cmd(cmd), .cmd_start(cmd_start), .dec_cmd(dec_cmd),
        .arith_start(arith_start), .convert_start(convert_start),
        .logic_start(logic_start)
    );

    alu_int_arith u_arith (
        .clk(clk), .reset(reset),
        .cmd(dec_cmd), .start(arith_start), .res(arith_res)
    );

    alu_fp_convert u_convert (
        .clk(clk), .reset(reset),
        .cmd(dec_cmd), .start(convert_start), .res(convert_res)
    );

    alu_result u_result (
        .clk(clk), .reset(reset),
        .cmd(dec_cmd), .logic_start(logic_start),
        .arith_res(arith_res), .convert_res(convert_res),
        .value(result_value), .flags(result_flags), .done(result_done)
    );

endmodule

/* verif/alu_checker.sv */
// ALU result checker
// Snoops APB accesses to the DUT
// Compares RESULT reads and STATUS flags, counts errors

`timescale 1ns/1ps

module alu_checker import alu_pkg::*, apb_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  apb_req_t   apb_req,
    input  apb_rsp_t   apb_rsp,
    input  alu_word_t  exp_value,
    input  alu_flags_t exp_flags,
    output int         mismatch_count,
    output int         failure_count,
    output int         result_checks
);

    logic access;
    logic read_access;

    assign access      = apb_req.psel && apb_req.penable;
    assign read_access = access && !apb_req.pwrite;

    initial begin
        mismatch_count = 0;
        failure_count  = 0;
        result_checks  = 0;
    end

    ////////////////////////////////////////
    // Error reporting
    ////////////////////////////////////////
    task automatic note_mismatch(input string msg);
        mismatch_count++;
        $display("Mismatch at time %0t: %s", $time, msg);
    endtask

    task automatic note_failure(input string msg);
        failure_count++;
        $display("Failure at time %0t: %s", $time, msg);
    endtask

    ////////////////////////////////////////
    // Bus monitor
    ////////////////////////////////////////
    always @(posedge clk) begin
        if (!reset && access) begin
            // No wait states in this slave
            if (apb_rsp.pready !== 1'b1)
                note_failure("pready was low in an access cycle");
            if (read_access && apb_req.paddr == REG_RESULT) begin
                result_checks++;
                if (apb_rsp.prdata !== exp_value)
                    note_mismatch($sformatf("RESULT read 0x%08h, expected 0x%08h",
                                            apb_rsp.prdata, exp_value));
            end
            // Flags only mean something once done is set
            if (read_access && apb_req.paddr == REG_STATUS && apb_rsp.prdata[1]) begin
                if (apb_rsp.prdata[3:2] !== exp_flags)
                    note_mismatch($sformatf("STATUS flags %b, expected %b",
                                            apb_rsp.prdata[3:2], exp_flags));
                if (apb_rsp.prdata[0])
                    note_mismatch("STATUS shows busy and done at once");
            end
        end
    end

endmodule

/* verif/alu_tb.sv */
// ALU testbench top
// Clock, reset and APB master tasks
// Xorshift stimulus and reference model of the ALU ops

`timescale 1ns/1ps

module alu_tb
    import alu_pkg::*, apb_pkg::*;
();

    localparam int ADDR_WIDTH    = 8;
    localparam int RANDOM_PER_OP = 50;
    localparam int ARITH_RANDOM  = 80;
    localparam int CONV_RANDOM   = 20;
    // Reset, bitwise, alias, arith, conversion and bus tests
    localparam int TEST_COUNT  = 1 + 6 * RANDOM_PER_OP + 3 + ARITH_RANDOM + 13
                                 + 2 * CONV_RANDOM + 15 + 1;
    localparam int CYCLE_LIMIT = TEST_COUNT * 60 + 1000;

    typedef struct packed {
        alu_word_t  value;
        alu_flags_t flags;
    } expect_t;

    logic        clk;
    logic        reset;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    alu_word_t   exp_value;
    alu_flags_t  exp_flags;
    int          mismatch_count, failure_count, result_checks;
    int          cycle_count = 0;
    int          tests_run = 0;
    int          result_reads = 0;
    logic [31:0] rng_state;

    alu_top #(.ADDR_WIDTH(ADDR_WIDTH)) u_alu_top (
        .clk(clk), .reset(reset), .apb_req(apb_req), .apb_rsp(apb_rsp)
    );

    alu_checker u_checker (
        .clk(clk), .reset(reset), .apb_req(apb_req), .apb_rsp(apb_rsp),
        .exp_value(exp_value), .exp_flags(exp_flags),
        .mismatch_count(mismatch_count), .failure_count(failure_count),
        .result_checks(result_checks)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the DUT never reported done", cycle_count);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] random_word();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // Expected value and flags of one operation
    function automatic expect_t expected_result(input logic [3:0] op,
                                                input alu_word_t a, input alu_word_t b);
        logic [3:0]  code;
        alu_word_t   v;
        logic        err;
        logic        flagged;
        longint      wide;
        logic [31:0] m;
        logic [23:0] sig;
        int          p;
        int          e;
        code    = op[3] ? {2'b10, op[1:0]} : op;
        v       = '0;
        err     = 1'b0;
        flagged = 1'b1;
        case (alu_op_e'(code))
            OP_ADD: begin
                v   = a + b;
                err = (a[31] == b[31]) && (v[31] != a[31]);
            end
            OP_SUB: begin
                v   = a - b;
                err = (a[31] != b[31]) && (v[31] != a[31]);
            end
            OP_MUL: begin
                wide = longint'(a) * longint'(b);
                v    = wide[31:0];
            end
            OP_DIV: begin
                if (b == 0) begin
                    v   = '1;
                    err = 1'b1;
                end else begin
                    wide = longint'(a) / longint'(b);
                    v    = wide[31:0];
                end
            end
            OP_ITOF: begin
                m = a[31] ? -a : a;
                if (m != 0) begin
                    p = 31;
                    while (!m[p])
                        p--;
                    if (p >= 23)
                        sig = 24'(m >> (p - 23));
                    else
                        sig = 24'(m << (23 - p));
                    v = {a[31], 8'(127 + p), sig[22:0]};
                end
            end
            OP_FTOI: begin
                e   = int'(a[30:23]) - 127;
                sig = {1'b1, a[22:0]};
                if (a[30:23] == 8'hFF || e >= 31) begin
                    v = a[31] ? 32'h8000_0000 : 32'h7FFF_FFFF;
                end else if (e >= 0) begin
                    m = (e >= 23) ? 32'(sig) << (e - 23) : 32'(sig) >> (23 - e);
                    v = a[31] ? -m : m;
                end
            end
            default: begin
                flagged = 1'b0;
                case (alu_op_e'(code))
                    OP_NOT:        v = ~a;
                    OP_AND:        v = a & b;
                    OP_OR:         v = a | b;
                    OP_XOR:        v = a ^ b;
                    OP_WRITE_HIGH: v = {b[15:0], a[15:0]};
                    default:       v = {a[31:16], b[15:0]};
                endcase
            end
        endcase
        return '{value: v, flags: flagged ? {err, v == 0} : 2'b00};
    endfunction

    ////////////////////////////////////////
    // APB master
    ////////////////////////////////////////
    task automatic apb_write(input apb_addr_t addr, input logic [31:0] data,
                             input logic expect_err);
        @(negedge clk);
        apb_req = '{paddr: addr, psel: 1'b1, penable: 1'b0, pwrite: 1'b1, pwdata: data};
        @(negedge clk);
        apb_req.penable = 1'b1;
        @(posedge clk);
        if (apb_rsp.pslverr !== expect_err)
            u_checker.note_failure($sformatf("write to offset 0x%02h gave pslverr %b",
                                             addr, apb_rsp.pslverr));
        @(negedge clk);
        apb_req = '0;
    endtask

    task automatic apb_read(input apb_addr_t addr, output logic [31:0] data,
                            input logic expect_err);
        @(negedge clk);
        apb_req = '{paddr: addr, psel: 1'b1, penable: 1'b0, pwrite: 1'b0, pwdata: '0};
        @(negedge clk);
        apb_req.penable = 1'b1;
        @(posedge clk);
        data = apb_rsp.prdata;
        if (addr == REG_RESULT)
            result_reads++;
        if (apb_rsp.pslverr !== expect_err)
            u_checker.note_failure($sformatf("read of offset 0x%02h gave pslverr %b",
                                             addr, apb_rsp.pslverr));
        @(negedge clk);
        apb_req = '0;
    endtask

    task automatic wait_done();
        logic [31:0] status;
        status = '0;
        while (!status[1])
            apb_read(REG_STATUS, status, 1'b0);
    endtask

    // Operands, expectation, launch, poll and read back of one command
    task automatic run_op(input logic [3:0] op, input alu_word_t a, input alu_word_t b);
        expect_t     expected;
        logic [31:0] data;
        expected = expected_result(op, a, b);
        apb_write(REG_OP1, a, 1'b0);
        apb_write(REG_OP2, b, 1'b0);
        exp_value = expected.value;
        exp_flags = expected.flags;
        apb_write(REG_CTRL, {28'd0, op}, 1'b0);
        wait_done();
        apb_read(REG_RESULT, data, 1'b0);
        tests_run++;
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////
    initial begin : stimulus
        logic [31:0] data;
        logic [31:0] r;
        alu_word_t   a, b;
        expect_t     expected;
        apb_req   = '0;
        reset     = 1'b1;
        exp_value = '0;
        exp_flags = '0;
        rng_state = 32'd14;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // Reset state
        apb_read(REG_STATUS, data, 1'b0);
        if (data[1:0] !== 2'b00)
            u_checker.note_mismatch($sformatf("STATUS after reset 0x%08h", data));
        // RESULT reads zero after reset
        apb_read(REG_RESULT, data, 1'b0);
        apb_read(REG_OP1, data, 1'b0);
        if (data !== '0)
            u_checker.note_mismatch($sformatf("OP1 after reset 0x%08h", data));
        apb_read(REG_OP2, data, 1'b0);
        if (data !== '0)
            u_checker.note_mismatch($sformatf("OP2 after reset 0x%08h", data));

        // NOT through WRITE_LOW as codes 4 to 9
        for (int k = 4; k < 10; k++) begin
            for (int i = 0; i < RANDOM_PER_OP; i++) begin
                a = random_word();
                b = random_word();
                run_op(4'(k), a, b);
            end
        end
        // 11xx aliases
        run_op(4'b1100, 32'h1234_5678, 32'h9ABC_DEF0);
        run_op(4'b1101, 32'h1234_5678, 32'h9ABC_DEF0);
        run_op(4'b1110, -32'sd1000, 32'd0);

        for (int i = 0; i < ARITH_RANDOM; i++) begin
            r = random_word();
            a = random_word();
            b = random_word();
            // Short divisors give longer quotients
            if (r[2])
                b = b >>> r[7:3];
            run_op({2'b00, r[1:0]}, a, b);
        end
        run_op(OP_ADD, 32'h7FFF_FFFF, 32'd1);
        run_op(OP_ADD, 32'h8000_0000, 32'hFFFF_FFFF);
        run_op(OP_ADD, 32'd5, -32'sd5);
        run_op(OP_SUB, 32'h8000_0000, 32'd1);
        run_op(OP_SUB, 32'h7FFF_FFFF, 32'hFFFF_FFFF);
        run_op(OP_SUB, 32'd7, 32'd7);
        run_op(OP_MUL, 32'h0001_0000, 32'h0001_0000);
        run_op(OP_MUL, -32'sd3, 32'd7);
        run_op(OP_DIV, -32'sd7, 32'd2);
        run_op(OP_DIV, 32'd7, -32'sd2);
        run_op(OP_DIV, 32'h8000_0000, -32'sd1);
        run_op(OP_DIV, 32'd1234, 32'd0);
        run_op(OP_DIV, 32'd0, 32'd5);

        for (int i = 0; i < CONV_RANDOM; i++) begin
            a = alu_word_t'(random_word()) >>> (random_word() % 32);
            run_op(OP_ITOF, a, '0);
        end
        run_op(OP_ITOF, 32'd0, '0);
        run_op(OP_ITOF, -32'sd1, '0);
        run_op(OP_ITOF, 32'h8000_0000, '0);
        run_op(OP_ITOF, 32'd1, '0);
        run_op(OP_ITOF, 32'h7FFF_FFFF, '0);

        // Exponents from 110 to 165 span fractions and saturation
        for (int i = 0; i < CONV_RANDOM; i++) begin
            r = random_word();
            a = {r[31], 8'd110 + 8'(r[30:23] % 56), r[22:0]};
            run_op(OP_FTOI, a, '0);
        end
        run_op(OP_FTOI, 32'h3F00_0000, '0);
        run_op(OP_FTOI, 32'h3F7F_FFFF, '0);
        run_op(OP_FTOI, 32'hBF80_0000, '0);
        run_op(OP_FTOI, 32'h42F6_E979, '0);
        run_op(OP_FTOI, 32'h7FC0_0000, '0);
        run_op(OP_FTOI, 32'hFF80_0000, '0);
        run_op(OP_FTOI, 32'h4F00_0000, '0);
        run_op(OP_FTOI, 32'hCF80_0000, '0);
        run_op(OP_FTOI, 32'h4EFF_FFFF, '0);
        run_op(OP_FTOI, 32'h0040_0000, '0);

        // CTRL write refused while a divide runs
        a = -32'sd100000;
        b = 32'd37;
        expected  = expected_result(OP_DIV, a, b);
        exp_value = expected.value;
        exp_flags = expected.flags;
        apb_write(REG_OP1, a, 1'b0);
        apb_write(REG_OP2, b, 1'b0);
        apb_write(REG_CTRL, {28'd0, OP_DIV}, 1'b0);
        apb_write(REG_CTRL, {28'd0, OP_ADD}, 1'b1);
        wait_done();
        apb_read(REG_RESULT, data, 1'b0);
        apb_write(REG_RESULT, 32'h1234_5678, 1'b1);
        apb_read(32'h1C, data, 1'b1);
        if (data !== '0)
            u_checker.note_mismatch($sformatf("unmapped read returned 0x%08h", data));
        tests_run++;

        if (result_checks != result_reads)
            u_checker.note_failure($sformatf("checker compared %0d of %0d RESULT reads",
                                             result_checks, result_reads));

        $display("Tests %0d, result checks %0d, mismatches %0d, other failures %0d",
                 tests_run, result_checks, mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

/* src.f */
hdl/alu_pkg.sv
hdl/apb_pkg.sv
hdl/alu_apb_regs.sv
hdl/alu_op_decode.sv
hdl/alu_int_arith.sv
hdl/alu_fp_convert.sv
hdl/alu_result.sv
hdl/alu_top.sv
verif/alu_checker.sv
verif/alu_tb.sv

/* Bender.yml */
package:
  name: alu_apb

sources:
  # Packages first, then RTL bottom up
  - hdl/alu_pkg.sv
  - hdl/apb_pkg.sv
  - hdl/alu_apb_regs.sv
  - hdl/alu_op_decode.sv
  - hdl/alu_int_arith.sv
  - hdl/alu_fp_convert.sv
  - hdl/alu_result.sv
  - hdl/alu_top.sv
  - target: test
    files:
      - verif/alu_checker.sv
      - verif/alu_tb.sv
